// ==== Bender.yml ====
package:
  name: serial_profiler

sources:
  - profiler_pkg.sv
  - insn_classifier.sv
  - class_queue.sv
  - savings_accumulator.sv
  - serial_profiler.sv
  - target: test
    files:
      - profiler_assertions.sv
      - tb_serial_profiler.sv

// ==== class_queue.sv ====
`default_nettype none

module class_queue import profiler_pkg::*; (
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire class_push_t i_push,
   input  wire              i_pop,
   output instr_class_e     o_head,
   output logic             o_empty
);

   instr_class_e        mem [QUEUE_DEPTH];
   logic [QPTR_W-1:0]   wr_ptr;
   logic [QPTR_W-1:0]   rd_ptr;
   logic [CREDIT_W-1:0] count;
   logic                wr_en;
   logic                rd_en;

   function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
      return (ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign o_empty = (count == '0);
   assign wr_en   = i_push.valid;
   assign rd_en   = i_pop & ~o_empty;
   assign o_head  = mem[rd_ptr];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // Push and pop together leave the count alone
         count <= count + CREDIT_W'(wr_en) - CREDIT_W'(rd_en);
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_push.cls;
      end
   end

endmodule

`default_nettype wire

// ==== insn_classifier.sv ====
`default_nettype none

module insn_classifier import profiler_pkg::*; (
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire              i_ibus_ack,
   input  wire [INSN_W-1:0] i_ibus_rdt,
   input  wire              i_credit_return,
   output class_push_t      o_push,
   output logic             o_fetch_ready,
   output logic [CNT_W-1:0] o_dropped
);

   logic [CREDIT_W-1:0] credits;
   logic                take;
   logic                push_valid;
   instr_class_e        push_cls;
   instr_class_e        fetch_cls;

   function automatic instr_class_e classify(input logic [INSN_W-1:0] insn);
      opcode_e      opc;
      logic [2:0]   funct3;
      logic [6:0]   funct7;
      instr_class_e cls;
      opc    = opcode_e'(insn[6:0]);
      funct3 = insn[14:12];
      funct7 = insn[31:25];
      cls    = CLS_OTHER;
      case (opc)
         OPC_LOAD: begin
            case (funct3)
               3'b000, 3'b100: cls = CLS_LOAD_BYTE;
               3'b001, 3'b101: cls = CLS_LOAD_HALF;
               default:        cls = CLS_OTHER;
            endcase
         end
         OPC_OP_IMM: begin
            // Shifts stay in the default class
            case (funct3)
               3'b000, 3'b100, 3'b110, 3'b111: cls = CLS_IMM_ALU;
               3'b010, 3'b011:                 cls = CLS_SET_LESS;
               default:                        cls = CLS_OTHER;
            endcase
         end
         OPC_OP: begin
            case (funct3)
               3'b000: begin
                  if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                     cls = CLS_REG_ALU;
                  end
               end
               3'b100, 3'b110, 3'b111: begin
                  if (funct7 == 7'b0000000) begin
                     cls = CLS_REG_ALU;
                  end
               end
               3'b010, 3'b011: begin
                  if (funct7 == 7'b0000000) begin
                     cls = CLS_SET_LESS;
                  end
               end
               default: cls = CLS_OTHER;
            endcase
         end
         OPC_MISC_MEM: begin
            if (funct3 == 3'b000) begin
               cls = CLS_FENCE;
            end
         end
         default: cls = CLS_OTHER;
      endcase
      return cls;
   endfunction

   assign fetch_cls     = classify(i_ibus_rdt);
   assign o_fetch_ready = (credits != '0);
   assign take          = i_ibus_ack & o_fetch_ready;
   assign o_push        = '{valid: push_valid, cls: push_cls};

   // One credit per free queue entry
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         credits    <= CREDIT_W'(QUEUE_DEPTH);
         push_valid <= 1'b0;
         o_dropped  <= '0;
      end else begin
         credits    <= credits + CREDIT_W'(i_credit_return) - CREDIT_W'(take);
         push_valid <= take;
         if (i_ibus_ack && !o_fetch_ready) begin
            o_dropped <= o_dropped + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         push_cls <= fetch_cls;
      end
   end

endmodule

`default_nettype wire

// ==== profiler_assertions.sv ====
`default_nettype none

module profiler_assertions import profiler_pkg::*; (
   input wire                clk,
   input wire                i_rst_n,
   input wire class_push_t   i_push,
   input wire [CREDIT_W-1:0] i_count,
   input wire                i_empty
);

   timeunit 1ns;
   timeprecision 100ps;

   // Credits must keep pushes away from a full queue
   push_not_full: assert property (
      @(posedge clk) disable iff (!i_rst_n)
         i_push.valid |-> (i_count != CREDIT_W'(QUEUE_DEPTH))
   ) else $error("push while queue full");

   count_in_range: assert property (
      @(posedge clk) disable iff (!i_rst_n) i_count <= CREDIT_W'(QUEUE_DEPTH)
   ) else $error("queue occupancy above depth");

   empty_after_reset: assert property (
      @(posedge clk) $rose(i_rst_n) |-> i_empty
   ) else $error("queue not empty after reset");

endmodule

bind class_queue profiler_assertions u_assertions (
   .clk     (clk),
   .i_rst_n (i_rst_n),
   .i_push  (i_push),
   .i_count (count),
   .i_empty (o_empty)
);

`default_nettype wire

// ==== profiler_pkg.sv ====
`default_nettype none

package profiler_pkg;

   localparam int INSN_W      = 32;
   localparam int CNT_W       = 32;
   localparam int SAVED_W     = 6;
   localparam int POS_W       = 5;
   localparam int LAST_POS    = (1 << POS_W) - 1;
   localparam int QUEUE_DEPTH = 4;
   localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
   localparam int CREDIT_W    = 3;

   // Immediates assumed to settle at bit 12
   localparam int IMM_FLIP_POS = 12;

   // Fixed savings in serial cycles
   localparam int LOAD_BYTE_SAVE = 24;
   localparam int LOAD_HALF_SAVE = 16;
   localparam int SET_LESS_SAVE  = 31;
   localparam int FENCE_SAVE     = 32;

   localparam int MIN12_CAP     = 20;
   localparam int GRAN16_THRESH = 15;
   localparam int GRAN16_STEP   = 16;

   typedef enum logic [2:0] {
      CLS_OTHER,
      CLS_LOAD_BYTE,
      CLS_LOAD_HALF,
      CLS_SET_LESS,
      CLS_FENCE,
      CLS_IMM_ALU,
      CLS_REG_ALU
   } instr_class_e;

   // RV32I major opcodes that matter for classification
   typedef enum logic [6:0] {
      OPC_LOAD     = 7'b0000011,
      OPC_MISC_MEM = 7'b0001111,
      OPC_OP_IMM   = 7'b0010011,
      OPC_OP       = 7'b0110011
   } opcode_e;

   typedef struct packed {
      logic cnt_en;
      logic cnt0;
      logic rs1;
      logic rs2;
   } serial_bits_t;

   typedef struct packed {
      logic         valid;
      instr_class_e cls;
   } class_push_t;

   typedef struct packed {
      logic [CNT_W-1:0] cycles;
      logic [CNT_W-1:0] retired;
      logic [CNT_W-1:0] saved_bit;
      logic [CNT_W-1:0] saved_16;
      logic [CNT_W-1:0] saved_min12;
   } prof_counts_t;

endpackage

`default_nettype wire

// ==== savings_accumulator.sv ====
`default_nettype none

module savings_accumulator import profiler_pkg::*; (
   input  wire               clk,
   input  wire               i_rst_n,
   input  wire serial_bits_t i_serial,
   input  wire               i_retire,
   input  wire instr_class_e i_head,
   input  wire               i_empty,
   output logic              o_pop,
   output logic              o_credit_return,
   output prof_counts_t      o_counts,
   output logic              o_underrun
);

   logic [POS_W-1:0]   bit_pos;
   logic [POS_W-1:0]   flip_rs1;
   logic [POS_W-1:0]   flip_rs2;
   logic               prev_rs1;
   logic               prev_rs2;
   logic [SAVED_W-1:0] saved;
   logic [SAVED_W-1:0] saved_min12;
   logic [SAVED_W-1:0] saved_16;

   function automatic logic [POS_W-1:0] max_pos(input logic [POS_W-1:0] a,
                                                 input logic [POS_W-1:0] b);
      return (a > b) ? a : b;
   endfunction

   assign o_pop           = i_retire & ~i_empty;
   assign o_credit_return = o_pop;

   // Cycles an early-terminating datapath would skip
   always_comb begin
      saved = '0;
      if (o_pop) begin
         case (i_head)
            CLS_LOAD_BYTE: saved = SAVED_W'(LOAD_BYTE_SAVE);
            CLS_LOAD_HALF: saved = SAVED_W'(LOAD_HALF_SAVE);
            CLS_SET_LESS:  saved = SAVED_W'(SET_LESS_SAVE);
            CLS_FENCE:     saved = SAVED_W'(FENCE_SAVE);
            CLS_IMM_ALU: begin
               saved = SAVED_W'(LAST_POS)
                     - SAVED_W'(max_pos(flip_rs1, POS_W'(IMM_FLIP_POS)));
            end
            CLS_REG_ALU: begin
               saved = SAVED_W'(LAST_POS) - SAVED_W'(max_pos(flip_rs1, flip_rs2));
            end
            default:       saved = '0;
         endcase
      end
   end

   assign saved_min12 = (saved > SAVED_W'(MIN12_CAP)) ? SAVED_W'(MIN12_CAP) : saved;
   assign saved_16    = (saved > SAVED_W'(GRAN16_THRESH)) ? SAVED_W'(GRAN16_STEP) : '0;

   // Last bit position where each operand stream toggled
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         bit_pos  <= '0;
         flip_rs1 <= '0;
         flip_rs2 <= '0;
         prev_rs1 <= 1'b0;
         prev_rs2 <= 1'b0;
      end else if (i_serial.cnt_en) begin
         bit_pos <= bit_pos + 1'b1;
         if (i_serial.cnt0) begin
            prev_rs1 <= i_serial.rs1;
            prev_rs2 <= i_serial.rs2;
            flip_rs1 <= '0;
            flip_rs2 <= '0;
         end else begin
            if (i_serial.rs1 != prev_rs1) begin
               flip_rs1 <= bit_pos;
               prev_rs1 <= i_serial.rs1;
            end
            if (i_serial.rs2 != prev_rs2) begin
               flip_rs2 <= bit_pos;
               prev_rs2 <= i_serial.rs2;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_counts   <= '0;
         o_underrun <= 1'b0;
      end else begin
         o_counts.cycles <= o_counts.cycles + 1'b1;
         if (i_retire) begin
            o_counts.retired     <= o_counts.retired + 1'b1;
            o_counts.saved_bit   <= o_counts.saved_bit + CNT_W'(saved);
            o_counts.saved_16    <= o_counts.saved_16 + CNT_W'(saved_16);
            o_counts.saved_min12 <= o_counts.saved_min12 + CNT_W'(saved_min12);
            // Sticky flag for a retire without a fetched class
            if (i_empty) begin
               o_underrun <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== serial_profiler.sv ====
`default_nettype none

module serial_profiler import profiler_pkg::*; (
   input  wire               clk,
   input  wire               i_rst_n,
   input  wire               i_ibus_ack,
   input  wire [INSN_W-1:0]  i_ibus_rdt,
   input  wire serial_bits_t i_serial,
   input  wire               i_retire,
   output logic              o_fetch_ready,
   output logic [CNT_W-1:0]  o_dropped,
   output prof_counts_t      o_counts,
   output logic              o_underrun
);

   class_push_t  push;
   instr_class_e head;
   logic         empty;
   logic         pop;
   logic         credit_return;

   insn_classifier u_classifier (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_ibus_ack      (i_ibus_ack),
      .i_ibus_rdt      (i_ibus_rdt),
      .i_credit_return (credit_return),
      .o_push          (push),
      .o_fetch_ready   (o_fetch_ready),
      .o_dropped       (o_dropped)
   );

   class_queue u_queue (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_push  (push),
      .i_pop   (pop),
      .o_head  (head),
      .o_empty (empty)
   );

   // Pops at retire and hands the credit back
   savings_accumulator u_accum (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_serial        (i_serial),
      .i_retire        (i_retire),
      .i_head          (head),
      .i_empty         (empty),
      .o_pop           (pop),
      .o_credit_return (credit_return),
      .o_counts        (o_counts),
      .o_underrun      (o_underrun)
   );

endmodule

`default_nettype wire

// ==== src.f ====
profiler_pkg.sv
insn_classifier.sv
class_queue.sv
savings_accumulator.sv
serial_profiler.sv
profiler_assertions.sv
tb_serial_profiler.sv

// ==== tb_serial_profiler.sv ====
`default_nettype none

module tb_serial_profiler import profiler_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [INSN_W-1:0] INSN_LB    = 32'h00010083;
   localparam logic [INSN_W-1:0] INSN_LH    = 32'h00011083;
   localparam logic [INSN_W-1:0] INSN_SLTI  = 32'h00512093;
   localparam logic [INSN_W-1:0] INSN_FENCE = 32'h0ff0000f;
   localparam logic [INSN_W-1:0] INSN_SW    = 32'h00112023;
   localparam logic [INSN_W-1:0] INSN_ADD   = 32'h002081b3;
   localparam logic [INSN_W-1:0] INSN_ADDI  = 32'h00110093;
   localparam logic [INSN_W-1:0] INSN_XOR   = 32'h0020c1b3;
   localparam int                IDLE_K     = 7;

   logic              clk;
   logic              i_rst_n;
   logic              i_ibus_ack;
   logic [INSN_W-1:0] i_ibus_rdt;
   serial_bits_t      i_serial;
   logic              i_retire;
   logic              o_fetch_ready;
   logic [CNT_W-1:0]  o_dropped;
   prof_counts_t      o_counts;
   logic              o_underrun;

   prof_counts_t      exp_counts;
   logic [CNT_W-1:0]  exp_dropped;
   logic [CNT_W-1:0]  tb_cycles = '0;
   integer            seed;
   int                errors;
   int                checks;
   int                tests;

   serial_profiler u_dut (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_ack    (i_ibus_ack),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_serial      (i_serial),
      .i_retire      (i_retire),
      .o_fetch_ready (o_fetch_ready),
      .o_dropped     (o_dropped),
      .o_counts      (o_counts),
      .o_underrun    (o_underrun)
   );

   always #20 clk = ~clk;

   // Reference clock count that ticks on every edge out of reset
   always @(posedge clk) begin
      if (i_rst_n) begin
         tb_cycles <= tb_cycles + 1'b1;
      end
   end

   task automatic check_count(input logic [CNT_W-1:0] act, input logic [CNT_W-1:0] exp,
                              input string name);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input logic act, input logic exp, input string name);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic check_counts(input prof_counts_t act, input prof_counts_t exp);
      check_count(act.cycles, exp.cycles, "o_counts.cycles");
      check_count(act.retired, exp.retired, "o_counts.retired");
      check_count(act.saved_bit, exp.saved_bit, "o_counts.saved_bit");
      check_count(act.saved_16, exp.saved_16, "o_counts.saved_16");
      check_count(act.saved_min12, exp.saved_min12, "o_counts.saved_min12");
   endtask

   task automatic report(input string name, input int errors_before);
      tests++;
      if (errors == errors_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, errors - errors_before);
      end
   endtask

   // Operand stream whose last change is at bit last_flip with random lower bits
   function automatic logic [31:0] make_stream(input int last_flip, input logic [31:0] rnd);
      logic [31:0] s;
      s = rnd;
      if (last_flip == 0) begin
         s = {32{rnd[0]}};
      end else begin
         for (int i = last_flip; i < 32; i++) begin
            s[i] = rnd[31];
         end
         s[last_flip-1] = ~rnd[31];
      end
      return s;
   endfunction

   task automatic wait_ready(input int limit);
      int n;
      n = 0;
      while (!o_fetch_ready && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!o_fetch_ready) begin
         errors++;
         $display("Timed out after %0d cycles waiting for o_fetch_ready", limit);
      end
   endtask

   task automatic fetch(input logic [INSN_W-1:0] word);
      i_ibus_ack = 1'b1;
      i_ibus_rdt = word;
      @(negedge clk);
      i_ibus_ack = 1'b0;
      @(negedge clk);
   endtask

   task automatic play_burst(input logic [31:0] rs1, input logic [31:0] rs2);
      for (int i = 0; i < 32; i++) begin
         i_serial = '{cnt_en: 1'b1, cnt0: (i == 0), rs1: rs1[i], rs2: rs2[i]};
         @(negedge clk);
      end
      i_serial = '0;
   endtask

   // Expected totals follow the cap and 16-cycle granularity rules
   task automatic retire(input int saving);
      i_retire = 1'b1;
      @(negedge clk);
      i_retire = 1'b0;
      exp_counts.retired   += 1;
      exp_counts.saved_bit += CNT_W'(saving);
      exp_counts.saved_min12 += CNT_W'((saving > MIN12_CAP) ? MIN12_CAP : saving);
      exp_counts.saved_16    += CNT_W'((saving > GRAN16_THRESH) ? 16 : 0);
      exp_counts.cycles = tb_cycles;
      check_counts(o_counts, exp_counts);
   endtask

   task automatic run_insn(input logic [INSN_W-1:0] word, input logic [31:0] rs1,
                           input logic [31:0] rs2, input int saving);
      wait_ready(16);
      fetch(word);
      play_burst(rs1, rs2);
      retire(saving);
   endtask

   task automatic test_reset_cycles();
      int               e0;
      logic [CNT_W-1:0] start;
      e0 = errors;
      check_bit(o_fetch_ready, 1'b1, "o_fetch_ready");
      check_bit(o_underrun, 1'b0, "o_underrun");
      check_count(o_dropped, '0, "o_dropped");
      check_counts(o_counts, exp_counts);
      start = o_counts.cycles;
      repeat (IDLE_K) @(negedge clk);
      check_count(o_counts.cycles - start, CNT_W'(IDLE_K), "o_counts.cycles delta");
      report("reset and cycle count", e0);
   endtask

   task automatic test_fixed_classes();
      int e0;
      e0 = errors;
      run_insn(INSN_LB, make_stream(0, $random(seed)), make_stream(0, $random(seed)), 24);
      run_insn(INSN_LH, make_stream(0, $random(seed)), make_stream(0, $random(seed)), 16);
      run_insn(INSN_SLTI, make_stream(0, $random(seed)), make_stream(0, $random(seed)), 31);
      run_insn(INSN_FENCE, make_stream(0, $random(seed)), make_stream(0, $random(seed)), 32);
      run_insn(INSN_SW, make_stream(0, $random(seed)), make_stream(0, $random(seed)), 0);
      report("fixed-rule classes", e0);
   endtask

   task automatic test_flip_tracking();
      int e0;
      e0 = errors;
      run_insn(INSN_ADD, make_stream(9, $random(seed)), make_stream(20, $random(seed)), 11);
      // Immediate flip at 12 dominates rs1 at 5
      run_insn(INSN_ADDI, make_stream(5, $random(seed)), $random(seed), 19);
      run_insn(INSN_XOR, make_stream(0, $random(seed)), make_stream(0, $random(seed)), 31);
      report("flip tracking", e0);
   endtask

   task automatic test_back_pressure();
      int e0;
      e0 = errors;
      fetch(INSN_LB);
      fetch(INSN_LH);
      fetch(INSN_SLTI);
      fetch(INSN_FENCE);
      check_bit(o_fetch_ready, 1'b0, "o_fetch_ready");
      fetch(INSN_ADD);
      exp_dropped += 1;
      check_count(o_dropped, exp_dropped, "o_dropped");
      retire(24);
      wait_ready(8);
      check_bit(o_fetch_ready, 1'b1, "o_fetch_ready");
      // Remaining entries come out in fetch order
      retire(16);
      retire(31);
      retire(32);
      check_count(o_dropped, exp_dropped, "o_dropped");
      report("credit back-pressure", e0);
   endtask

   task automatic test_underrun();
      int e0;
      e0 = errors;
      check_bit(o_underrun, 1'b0, "o_underrun");
      retire(0);
      check_bit(o_underrun, 1'b1, "o_underrun");
      repeat (3) @(negedge clk);
      check_bit(o_underrun, 1'b1, "o_underrun");
      exp_counts.cycles = tb_cycles;
      check_counts(o_counts, exp_counts);
      report("retire underrun", e0);
   endtask

   initial begin
      seed        = 32'hdf0e;
      clk         = 1'b0;
      i_rst_n     = 1'b0;
      i_ibus_ack  = 1'b0;
      i_ibus_rdt  = '0;
      i_serial    = '0;
      i_retire    = 1'b0;
      exp_counts  = '0;
      exp_dropped = '0;
      errors      = 0;
      checks      = 0;
      tests       = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      i_rst_n = 1'b1;
      test_reset_cycles();
      test_fixed_classes();
      test_flip_tracking();
      test_back_pressure();
      test_underrun();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
